/* trace_top.f */
src/trace_pkg.sv
src/trace_shift_window.sv
src/trace_rule_matcher.sv
src/trace_capture_ctrl.sv
src/trace_trigger_pulse.sv
src/trace_event_fifo.sv
src/trace_top.sv
sim/trace_checker.sv
sim/trace_assertions.sv
sim/trace_tb.sv

/* Makefile */
# Verilator build for the trace capture testbench

TOP = trace_tb

lint:
	verilator --lint-only --timing -f trace_top.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f trace_top.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "RESULT: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" sim.log || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log

.PHONY: lint sim clean

/* sim/trace_tb.sv */
// trace capture testbench
// clock, reset, random trace stimulus and rule setup, watchdog

`timescale 1ns/1ps
`default_nettype none

module trace_tb;
   import trace_pkg::*;

   localparam int NUM_TESTS = 7;
   localparam int OVERHEAD  = 140;   // setup, arm and drain cycles per test
   localparam int BEATS [NUM_TESTS] = '{200, 300, 200, 400, 300, 100, 300};

   logic                 trace_clk = 1'b0;
   logic                 reset, trace_valid, rule_wr, rule_record_en, rule_trig_en;
   logic                 arm, out_ready, out_valid, capturing, capture_done;
   logic                 overflow, trig_out, test_end;
   logic [NIBBLE_W-1:0]  trace_data;
   logic [RULE_ID_W-1:0] rule_index;
   window_t              rule_pattern, rule_mask;
   logic [CAPLEN_W-1:0]  capture_len;
   logic [DELAY_W-1:0]   trig_delay;
   logic [PULSE_W-1:0]   trig_width;
   logic [7:0]           test_num;
   event_t               out_data;
   int                   error_count, tests_failed;
   integer               seed;

   always #4 trace_clk = ~trace_clk;

   trace_top dut (.*);

   trace_checker u_checker (.*);

   function automatic window_t sparse_mask();
      return $random(seed) & $random(seed) & $random(seed);  // about 4 bits set
   endfunction

   task automatic write_rule(input int idx, input window_t mask, input bit rec, input bit trig);
      @(posedge trace_clk);
      rule_wr        <= 1'b1;
      rule_index     <= RULE_ID_W'(idx);
      rule_pattern   <= $random(seed);
      rule_mask      <= mask;
      rule_record_en <= rec;
      rule_trig_en   <= trig;
      @(posedge trace_clk);
      rule_wr <= 1'b0;
   endtask

   // sparse record rules 0 to 2 and trigger rule 3 that hits always or sparsely
   task automatic setup_rules(input bit easy);
      write_rule(0, sparse_mask(), 1'b1, 1'b0);
      write_rule(1, sparse_mask(), 1'b1, 1'b0);
      write_rule(2, easy ? window_t'(0) : sparse_mask(), 1'b1, 1'b0);
      write_rule(3, easy ? window_t'(0) : sparse_mask(), !easy, 1'b1);
   endtask

   task automatic start_capture(input int len);
      @(posedge trace_clk);
      capture_len <= CAPLEN_W'(len);
      trig_delay  <= DELAY_W'($unsigned($random(seed)) % 32);
      trig_width  <= PULSE_W'(1 + $unsigned($random(seed)) % 31);
      arm         <= 1'b1;
      @(posedge trace_clk);
      arm <= 1'b0;
      repeat (3) @(posedge trace_clk);
   endtask

   task automatic drive_beats(input int n, input int valid_pct, input int ready_mode);
      repeat (n) begin
         @(posedge trace_clk);
         trace_valid <= ($unsigned($random(seed)) % 100) < valid_pct;
         trace_data  <= NIBBLE_W'($random(seed));
         out_ready   <= (ready_mode == 0) ? 1'b1 :
                        (ready_mode == 1) ? 1'($random(seed)) : 1'b0;
      end
   endtask

   // drain the FIFO and let the trigger pulse finish, then close the test
   task automatic finish_test(input int num);
      int idle;
      idle = 0;
      @(posedge trace_clk);
      trace_valid <= 1'b0;
      out_ready   <= 1'b1;
      repeat (70) @(posedge trace_clk);
      for (int i = 0; i < 600 && idle < 8; i++) begin
         @(posedge trace_clk);
         idle = (out_valid || trig_out) ? 0 : idle + 1;
      end
      @(posedge trace_clk);
      test_num <= 8'(num);
      test_end <= 1'b1;
      @(posedge trace_clk);
      test_end <= 1'b0;
   endtask

   task automatic run_test(input int num, input bit easy, input int len,
                           input int valid_pct, input int ready_mode);
      setup_rules(easy);
      start_capture(len);
      drive_beats(BEATS[num-1], valid_pct, ready_mode);
      finish_test(num);
   endtask

   initial begin
      seed = 91;
      reset = 1'b1;
      trace_valid = 1'b0;
      trace_data = '0;
      rule_wr = 1'b0;
      rule_index = '0;
      rule_pattern = '0;
      rule_mask = '0;
      rule_record_en = 1'b0;
      rule_trig_en = 1'b0;
      arm = 1'b0;
      capture_len = '0;
      trig_delay = '0;
      trig_width = 12'd1;
      out_ready = 1'b1;
      test_end = 1'b0;
      test_num = '0;
      repeat (8) @(posedge trace_clk);
      reset <= 1'b0;
      repeat (4) @(posedge trace_clk);

      run_test(1, 1'b1, 12, 75, 0);   // masked matching and priority
      run_test(2, 1'b0, 6, 75, 0);    // trigger start and pulse
      run_test(3, 1'b0, 3, 75, 0);    // capture length
      run_test(4, 1'b1, 5, 20, 0);    // timestamps with wide gaps
      run_test(5, 1'b1, 10, 75, 1);   // random back-pressure
      run_test(6, 1'b1, 24, 75, 2);   // overflow with ready held low
      run_test(7, 1'b0, 8, 75, 1);    // re-arm after overflow

      repeat (4) @(posedge trace_clk);
      $display("%0d tests, %0d failed, %0d errors", NUM_TESTS, tests_failed, error_count);
      if (error_count == 0 && tests_failed == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

   // watchdog at twice the planned length of all tests
   initial begin
      longint total;
      total = 20;
      for (int i = 0; i < NUM_TESTS; i++)
         total += BEATS[i] + OVERHEAD;
      #(total * 2 * 8);
      $display("watchdog expired before the tests finished");
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* sim/trace_assertions.sv */
// trace capture assertions
// output hold under back-pressure, exclusive capture state, pulse length

`timescale 1ns/1ps
`default_nettype none

module trace_assertions (
   input wire                         trace_clk,
   input wire                         reset,
   input wire                         out_valid,
   input wire                         out_ready,
   input trace_pkg::event_t           out_data,
   input wire                         capturing,
   input wire                         capture_done,
   input wire                         trig_out,
   input wire [trace_pkg::PULSE_W-1:0] trig_width
);
   import trace_pkg::*;

   int high_run;   // consecutive trig_out cycles so far

   always @(posedge trace_clk) begin
      if (reset || !trig_out)
         high_run <= 0;
      else
         high_run <= high_run + 1;
   end

   hold_a: assert property (@(posedge trace_clk) disable iff (reset)
      out_valid && !out_ready |=> out_valid && $stable(out_data))
      else $error("output changed while stalled");

   state_a: assert property (@(posedge trace_clk) disable iff (reset)
      !(capturing && capture_done))
      else $error("capturing and capture_done both high");

   width_a: assert property (@(posedge trace_clk) disable iff (reset)
      trig_out |-> high_run < int'(trig_width))
      else $error("trigger pulse longer than its width");

endmodule

bind trace_top trace_assertions u_assert (.*);

`default_nettype wire

/* sim/trace_checker.sv */
// trace capture checker
// reference model of window, rules and capture; compares events,
// trigger timing and end-of-test state against the DUT

`timescale 1ns/1ps
`default_nettype none

module trace_checker (
   input  wire                           trace_clk,
   input  wire                           reset,
   input  wire                           trace_valid,
   input  wire [trace_pkg::NIBBLE_W-1:0]  trace_data,
   input  wire                           rule_wr,
   input  wire [trace_pkg::RULE_ID_W-1:0] rule_index,
   input  trace_pkg::window_t            rule_pattern,
   input  trace_pkg::window_t            rule_mask,
   input  wire                           rule_record_en,
   input  wire                           rule_trig_en,
   input  wire                           arm,
   input  wire [trace_pkg::CAPLEN_W-1:0]  capture_len,
   input  wire [trace_pkg::DELAY_W-1:0]   trig_delay,
   input  wire [trace_pkg::PULSE_W-1:0]   trig_width,
   input  wire                           out_ready,
   input  wire                           out_valid,
   input  trace_pkg::event_t             out_data,
   input  wire                           capturing,
   input  wire                           capture_done,
   input  wire                           overflow,
   input  wire                           trig_out,
   input  wire                           test_end,
   input  wire [7:0]                     test_num,
   output int                            error_count,
   output int                            tests_failed
);
   import trace_pkg::*;

   localparam int ST_IDLE = 0, ST_ARMED = 1, ST_CAP = 2, ST_DONE = 3;

   window_t   pat [NUM_RULES];
   window_t   msk [NUM_RULES];
   rule_vec_t rec_en;
   rule_vec_t trig_en;
   window_t   win;
   int        fill;
   int        state;
   int        ev_cnt;
   int        test_errs;
   int        trig_len;
   longint    cyc;
   longint    last_ev;
   longint    cap_rise;
   longint    cap_rise_exp;
   event_t    exp_q [$];
   event_t    got;
   logic      exp_ovf;
   logic      cap_q;
   logic      trig_q;
   logic      arm_q;
   logic      pulse_seen;

   task automatic report(input string msg);
      $display("FAILED %0t: %s", $time, msg);
      error_count++;
      test_errs++;
   endtask

   // one beat with a full window, rule compare and capture model
   task automatic process_beat();
      rule_vec_t rh;
      rule_vec_t th;
      event_t    e;
      longint    gap;
      int        id;
      rh = '0;
      th = '0;
      id = -1;
      for (int i = 0; i < NUM_RULES; i++) begin
         if ((win & msk[i]) == (pat[i] & msk[i])) begin
            rh[i] = rec_en[i];
            th[i] = trig_en[i];
         end
      end
      for (int i = 0; i < NUM_RULES; i++)
         if (rh[i] && id < 0) id = i;   // lowest numbered rule
      if (state == ST_ARMED && th != '0) begin
         state = ST_CAP;
         cap_rise_exp = cyc + 3;
      end
      if (state == ST_CAP && id >= 0 && ev_cnt < int'(capture_len)) begin
         gap = cyc - last_ev;
         e.rule_id = RULE_ID_W'(id);
         e.delta = (ev_cnt == 0) ? '0 : (gap > 65535 ? 16'hffff : 16'(gap));
         last_ev = cyc;
         ev_cnt++;
         if (exp_q.size() >= FIFO_DEPTH)
            exp_ovf = 1'b1;    // dropped by a full FIFO
         else
            exp_q.push_back(e);
      end
      if (state == ST_CAP && ev_cnt >= int'(capture_len))
         state = ST_DONE;
   endtask

   initial begin
      error_count  = 0;
      tests_failed = 0;
      test_errs    = 0;
      cyc          = 0;
   end

   always @(posedge trace_clk) begin
      cyc++;
      if (reset) begin
         rec_en = '0;
         trig_en = '0;
         for (int i = 0; i < NUM_RULES; i++) begin
            pat[i] = '0;
            msk[i] = '0;
         end
         fill = 0;
         state = ST_IDLE;
         ev_cnt = 0;
         exp_ovf = 1'b0;
         cap_q = 1'b0;
         trig_q = 1'b0;
         arm_q = 1'b0;
         pulse_seen = 1'b0;
         cap_rise_exp = -1;
         exp_q.delete();
      end else begin
         if (arm_q && (capture_done || overflow))
            report("capture_done or overflow still set after arm");
         arm_q = arm;
         if (rule_wr) begin
            pat[rule_index] = rule_pattern;
            msk[rule_index] = rule_mask;
            rec_en[rule_index] = rule_record_en;
            trig_en[rule_index] = rule_trig_en;
         end
         if (trace_valid)
            win = {win[WINDOW_W-NIBBLE_W-1:0], trace_data};
         if (arm) begin
            state = ST_ARMED;
            ev_cnt = 0;
            fill = trace_valid ? 1 : 0;
            exp_ovf = 1'b0;
            pulse_seen = 1'b0;
            cap_rise_exp = -1;
         end else if (trace_valid) begin
            if (fill < FILL_BEATS)
               fill++;
            if (fill == FILL_BEATS)
               process_beat();
         end

         if (out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
               report($sformatf("unexpected event rule %0d delta %0d",
                                out_data.rule_id, out_data.delta));
            end else begin
               got = exp_q.pop_front();
               if (out_data !== got)
                  report($sformatf("event rule %0d delta %0d, expected rule %0d delta %0d",
                                   out_data.rule_id, out_data.delta, got.rule_id, got.delta));
            end
         end

         if (capturing && !cap_q) begin
            cap_rise = cyc;
            if (cyc != cap_rise_exp)
               report("capturing rose on the wrong cycle");
         end
         if (trig_out && !trig_q) begin
            trig_len = 0;
            pulse_seen = 1'b1;
            if (cyc - cap_rise != longint'(trig_delay) + 1)
               report($sformatf("trig_out rose %0d cycles after capture start, expected %0d",
                                cyc - cap_rise, trig_delay + 1));
         end
         if (trig_out)
            trig_len++;
         if (!trig_out && trig_q && trig_len != int'(trig_width))
            report($sformatf("trig_out width %0d, expected %0d", trig_len, trig_width));
         cap_q = capturing;
         trig_q = trig_out;

         if (test_end) begin
            if (capture_done !== (state == ST_DONE))
               report("capture_done does not match the model");
            if (capturing !== (state == ST_CAP))
               report("capturing does not match the model");
            if (overflow !== exp_ovf)
               report($sformatf("overflow %0b, expected %0b", overflow, exp_ovf));
            if (exp_q.size() != 0)
               report($sformatf("%0d expected events never came out", exp_q.size()));
            if (state >= ST_CAP && !pulse_seen)
               report("no trigger pulse after capture start");
            $display("test %0d: %s (%0d errors)", test_num,
                     test_errs != 0 ? "failed" : "passed", test_errs);
            if (test_errs != 0)
               tests_failed++;
            test_errs = 0;
            exp_q.delete();
         end
      end
   end

endmodule

`default_nettype wire

/* src/trace_top.sv */
// trace capture top level
// shift window, rule matcher, capture control, trigger pulse and event FIFO

`timescale 1ns/1ps
`default_nettype none

module trace_top (
   input  wire                           trace_clk,
   input  wire                           reset,
   input  wire                           trace_valid,
   input  wire [trace_pkg::NIBBLE_W-1:0]  trace_data,
   input  wire                           rule_wr,
   input  wire [trace_pkg::RULE_ID_W-1:0] rule_index,
   input  trace_pkg::window_t            rule_pattern,
   input  trace_pkg::window_t            rule_mask,
   input  wire                           rule_record_en,
   input  wire                           rule_trig_en,
   input  wire                           arm,
   input  wire [trace_pkg::CAPLEN_W-1:0]  capture_len,
   input  wire [trace_pkg::DELAY_W-1:0]   trig_delay,
   input  wire [trace_pkg::PULSE_W-1:0]   trig_width,
   input  wire                           out_ready,
   output logic                          out_valid,
   output trace_pkg::event_t             out_data,
   output logic                          capturing,
   output logic                          capture_done,
   output logic                          overflow,
   output logic                          trig_out
);
   import trace_pkg::*;

   window_t   window;
   logic      window_valid;
   logic      window_update;
   rule_vec_t record_hits;
   rule_vec_t trigger_hits;
   logic      pulse_start;
   logic      event_wr;
   event_t    event_data;

   trace_shift_window u_window (
      .trace_clk     (trace_clk),
      .reset         (reset),
      .arm           (arm),
      .trace_valid   (trace_valid),
      .trace_data    (trace_data),
      .window        (window),
      .window_valid  (window_valid),
      .window_update (window_update)
   );

   trace_rule_matcher u_matcher (
      .trace_clk      (trace_clk),
      .reset          (reset),
      .rule_wr        (rule_wr),
      .rule_index     (rule_index),
      .rule_pattern   (rule_pattern),
      .rule_mask      (rule_mask),
      .rule_record_en (rule_record_en),
      .rule_trig_en   (rule_trig_en),
      .window         (window),
      .window_valid   (window_valid),
      .window_update  (window_update),
      .record_hits    (record_hits),
      .trigger_hits   (trigger_hits)
   );

   trace_capture_ctrl u_ctrl (
      .trace_clk    (trace_clk),
      .reset        (reset),
      .arm          (arm),
      .capture_len  (capture_len),
      .record_hits  (record_hits),
      .trigger_hits (trigger_hits),
      .capturing    (capturing),
      .capture_done (capture_done),
      .pulse_start  (pulse_start),
      .event_wr     (event_wr),
      .event_data   (event_data)
   );

   trace_trigger_pulse u_trigger (
      .trace_clk   (trace_clk),
      .reset       (reset),
      .pulse_start (pulse_start),
      .trig_delay  (trig_delay),
      .trig_width  (trig_width),
      .trig_out    (trig_out)
   );

   trace_event_fifo u_fifo (
      .trace_clk  (trace_clk),
      .reset      (reset),
      .arm        (arm),
      .event_wr   (event_wr),
      .event_data (event_data),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_data   (out_data),
      .overflow   (overflow)
   );

endmodule

`default_nettype wire

/* src/trace_event_fifo.sv */
// event FIFO
// circular buffer with a registered valid/ready output stage;
// writes into a full FIFO are dropped and set a sticky overflow flag

`timescale 1ns/1ps
`default_nettype none

module trace_event_fifo (
   input  wire               trace_clk,
   input  wire               reset,
   input  wire               arm,
   input  wire               event_wr,
   input  trace_pkg::event_t event_data,
   output logic              out_valid,
   input  wire               out_ready,
   output trace_pkg::event_t out_data,
   output logic              overflow
);
   import trace_pkg::*;

   event_t                mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic [FIFO_CNT_W-1:0] count;      // entries in mem without the output stage
   logic                  full;
   logic                  load;
   logic                  push;
   logic                  bypass;
   logic                  pull;

   assign full   = (count + FIFO_CNT_W'(out_valid)) == FIFO_CNT_W'(FIFO_DEPTH);
   assign load   = !out_valid || out_ready;   // output stage can take a new entry
   assign push   = event_wr && !full;
   assign pull   = load && (count != '0);
   assign bypass = push && load && (count == '0); // empty FIFO goes straight to output

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         out_valid <= 1'b0;
         overflow  <= 1'b0;
      end else begin
         if (arm)
            overflow <= 1'b0;
         if (event_wr && full)
            overflow <= 1'b1;
         if (load)
            out_valid <= pull || push;
         if (pull)
            rd_ptr <= rd_ptr + 1'b1;
         if (push && !bypass)
            wr_ptr <= wr_ptr + 1'b1;
         count <= count + FIFO_CNT_W'(push && !bypass) - FIFO_CNT_W'(pull);
      end
   end

   always_ff @(posedge trace_clk) begin
      if (push && !bypass)
         mem[wr_ptr] <= event_data;
      if (load)
         out_data <= pull ? mem[rd_ptr] : event_data;
   end

endmodule

`default_nettype wire

/* src/trace_trigger_pulse.sv */
// trigger output pulse
// delay counter then width counter, settings latched at pulse_start

`timescale 1ns/1ps
`default_nettype none

module trace_trigger_pulse (
   input  wire                         trace_clk,
   input  wire                         reset,
   input  wire                         pulse_start,
   input  wire [trace_pkg::DELAY_W-1:0] trig_delay,
   input  wire [trace_pkg::PULSE_W-1:0] trig_width,
   output logic                        trig_out
);
   import trace_pkg::*;

   logic               delaying;
   logic [DELAY_W-1:0] delay_cnt;
   logic [PULSE_W-1:0] width_q;     // latched width
   logic [PULSE_W-1:0] width_cnt;
   logic               fire;

   // zero delay fires straight from the start pulse
   assign fire = (pulse_start && trig_delay == '0) ||
                 (!pulse_start && delaying && delay_cnt == DELAY_W'(1));

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         delaying <= 1'b0;
         trig_out <= 1'b0;
      end else begin
         if (pulse_start) begin
            width_q   <= trig_width;
            delay_cnt <= trig_delay;
            delaying  <= (trig_delay != '0);
         end else if (delaying) begin
            delay_cnt <= delay_cnt - 1'b1;
            if (delay_cnt == DELAY_W'(1))
               delaying <= 1'b0;
         end

         if (fire) begin
            trig_out  <= 1'b1;
            width_cnt <= pulse_start ? trig_width : width_q;
         end else if (trig_out) begin
            if (width_cnt == PULSE_W'(1))
               trig_out <= 1'b0;     // last high cycle
            width_cnt <= width_cnt - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* src/trace_capture_ctrl.sv */
// trace capture control
// arm / trigger / record FSM; builds one event per recorded match with
// the priority rule number and a saturating time since the last event

`timescale 1ns/1ps
`default_nettype none

module trace_capture_ctrl (
   input  wire                          trace_clk,
   input  wire                          reset,
   input  wire                          arm,
   input  wire [trace_pkg::CAPLEN_W-1:0] capture_len,
   input  trace_pkg::rule_vec_t         record_hits,
   input  trace_pkg::rule_vec_t         trigger_hits,
   output logic                         capturing,
   output logic                         capture_done,
   output logic                         pulse_start,
   output logic                         event_wr,
   output trace_pkg::event_t            event_data
);
   import trace_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ARMED,
      ST_CAPTURE,
      ST_DONE
   } state_t;

   state_t                state;
   logic [CAPLEN_W-1:0]    ev_cnt;
   logic [TIMESTAMP_W-1:0] ts_cnt;
   logic [RULE_ID_W-1:0]   hit_id;
   logic                   trig_now;
   logic                   take_event;

   assign trig_now = (state == ST_ARMED) && (trigger_hits != '0);

   // the trigger cycle itself may also record
   assign take_event = (record_hits != '0) &&
                       (trig_now || (state == ST_CAPTURE && ev_cnt < capture_len));

   // lowest numbered rule wins
   always_comb begin
      hit_id = '0;
      for (int i = NUM_RULES - 1; i >= 0; i--) begin
         if (record_hits[i])
            hit_id = RULE_ID_W'(i);
      end
   end

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         state       <= ST_IDLE;
         ev_cnt      <= '0;
         ts_cnt      <= '0;
         pulse_start <= 1'b0;
         event_wr    <= 1'b0;
      end else begin
         pulse_start <= trig_now && !arm;
         event_wr    <= take_event && !arm;

         if (ts_cnt != '1)
            ts_cnt <= ts_cnt + 1'b1;   // saturates at all ones

         if (arm) begin
            state  <= ST_ARMED;
            ev_cnt <= '0;
         end else begin
            if (take_event) begin
               ev_cnt <= ev_cnt + 1'b1;
               ts_cnt <= TIMESTAMP_W'(1);
            end
            case (state)
               ST_ARMED:   if (trig_now) state <= ST_CAPTURE;
               ST_CAPTURE: if (ev_cnt >= capture_len) state <= ST_DONE;
               default:    state <= state;   // idle and done wait for arm
            endcase
         end
      end
   end

   // event record
   always_ff @(posedge trace_clk) begin
      if (take_event) begin
         event_data.rule_id <= hit_id;
         event_data.delta   <= (ev_cnt == '0) ? '0 : ts_cnt; // first event is 0
      end
   end

   assign capturing    = (state == ST_CAPTURE);
   assign capture_done = (state == ST_DONE);

endmodule

`default_nettype wire

/* src/trace_rule_matcher.sv */
// trace rule matcher
// four mask-and-pattern rules compared against the window in parallel,
// hits registered and split into record and trigger vectors

`timescale 1ns/1ps
`default_nettype none

module trace_rule_matcher (
   input  wire                           trace_clk,
   input  wire                           reset,
   input  wire                           rule_wr,
   input  wire [trace_pkg::RULE_ID_W-1:0] rule_index,
   input  trace_pkg::window_t            rule_pattern,
   input  trace_pkg::window_t            rule_mask,
   input  wire                           rule_record_en,
   input  wire                           rule_trig_en,
   input  trace_pkg::window_t            window,
   input  wire                           window_valid,
   input  wire                           window_update,
   output trace_pkg::rule_vec_t          record_hits,
   output trace_pkg::rule_vec_t          trigger_hits
);
   import trace_pkg::*;

   window_t   pattern_tbl [NUM_RULES];
   window_t   mask_tbl    [NUM_RULES];
   rule_vec_t rec_en_tbl;
   rule_vec_t trig_en_tbl;
   rule_vec_t match;

   // rule table written one entry at a time
   always_ff @(posedge trace_clk) begin
      if (reset) begin
         for (int i = 0; i < NUM_RULES; i++) begin
            pattern_tbl[i] <= '0;
            mask_tbl[i]    <= '0;
         end
         rec_en_tbl  <= '0;
         trig_en_tbl <= '0;
      end else if (rule_wr) begin
         pattern_tbl[rule_index] <= rule_pattern;
         mask_tbl[rule_index]    <= rule_mask;
         rec_en_tbl[rule_index]  <= rule_record_en;
         trig_en_tbl[rule_index] <= rule_trig_en;
      end
   end

   // compare only where the mask is set
   always_comb begin
      for (int i = 0; i < NUM_RULES; i++)
         match[i] = ((window ^ pattern_tbl[i]) & mask_tbl[i]) == '0;
   end

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         record_hits  <= '0;
         trigger_hits <= '0;
      end else if (window_update && window_valid) begin
         record_hits  <= match & rec_en_tbl;
         trigger_hits <= match & trig_en_tbl;
      end else begin
         record_hits  <= '0;   // hits last a single cycle
         trigger_hits <= '0;
      end
   end

endmodule

`default_nettype wire

/* src/trace_shift_window.sv */
// trace shift window
// collects incoming trace nibbles into the 32-bit match window and
// flags when the window has been completely refilled since the last arm

`timescale 1ns/1ps
`default_nettype none

module trace_shift_window (
   input  wire                         trace_clk,
   input  wire                         reset,
   input  wire                         arm,
   input  wire                         trace_valid,
   input  wire [trace_pkg::NIBBLE_W-1:0] trace_data,
   output trace_pkg::window_t          window,
   output logic                        window_valid,
   output logic                        window_update
);
   import trace_pkg::*;

   logic [FILL_CNT_W-1:0] fill_cnt;

   // newest nibble enters at the bottom
   always_ff @(posedge trace_clk) begin
      if (trace_valid)
         window <= {window[WINDOW_W-NIBBLE_W-1:0], trace_data};
   end

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         fill_cnt      <= '0;
         window_update <= 1'b0;
      end else begin
         window_update <= trace_valid;
         if (arm)
            fill_cnt <= trace_valid ? FILL_CNT_W'(1) : '0; // restart fill
         else if (trace_valid && !window_valid)
            fill_cnt <= fill_cnt + 1'b1;
      end
   end

   assign window_valid = (fill_cnt == FILL_CNT_W'(FILL_BEATS));

endmodule

`default_nettype wire

/* src/trace_pkg.sv */
// trace capture shared definitions
// widths, counts and the event record used across the capture blocks

`default_nettype none

package trace_pkg;

   localparam int NIBBLE_W    = 4;   // one trace beat
   localparam int WINDOW_W    = 32;
   localparam int NUM_RULES   = 4;
   localparam int RULE_ID_W   = 2;
   localparam int TIMESTAMP_W = 16;
   localparam int DELAY_W     = 16;
   localparam int PULSE_W     = 12;
   localparam int CAPLEN_W    = 16;
   localparam int FIFO_DEPTH  = 16;

   // beats needed before the window holds only fresh data
   localparam int FILL_BEATS  = WINDOW_W / NIBBLE_W;
   localparam int FILL_CNT_W  = $clog2(FILL_BEATS + 1);

   localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_W  = $clog2(FIFO_DEPTH + 1);

   typedef logic [WINDOW_W-1:0]  window_t;   // window, pattern or mask
   typedef logic [NUM_RULES-1:0] rule_vec_t;

   typedef struct packed {
      logic [RULE_ID_W-1:0]   rule_id;
      logic [TIMESTAMP_W-1:0] delta;    // cycles since previous event
   } event_t;

endpackage

`default_nettype wire
